//--- hdl/gvp_pkg.sv
package gvp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // vector list geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int num_vectors_n2 = 3;                  // slot index width
    localparam int num_vectors    = 1 << num_vectors_n2; // 8 slots

    typedef logic        [num_vectors_n2-1:0] vec_addr_t; // vector slot index
    typedef logic        [31:0]               count_t;    // points, steps, repeats
    typedef logic signed [31:0]               coord_t;    // position or increment
    typedef logic signed [7:0]                jump_t;     // relative jump in slots

    // bus words
    typedef logic [3:0]  wb_adr_t;  // one word per register
    typedef logic [31:0] wb_data_t;

    // sample kind seen by the consumer
    typedef enum logic [1:0] {
        store_none   = 2'd0,
        store_data   = 2'd1, // data point reached
        store_header = 2'd2  // vector just loaded
    } store_e;

    typedef enum logic [1:0] {
        st_hold, // reset mode
        st_load, // fetch vector at pc
        st_step, // walking points and steps
        st_done  // end vector seen
    } gvp_state_e;

    // one program entry in register map order
    typedef struct packed {
        count_t   n;       // points minus one and zero ends the program
        count_t   iin;     // intermediate steps per point
        wb_data_t options; // passed through to samples
        count_t   nrep;    // extra passes through the loop
        jump_t    next;    // jump taken while repeating
        coord_t   dx;
        coord_t   dy;
        coord_t   dz;
        coord_t   du;
    } vector_t;

    // output stream word
    typedef struct packed {
        store_e   store;
        count_t   section;
        wb_data_t options;
        coord_t   x;
        coord_t   y;
        coord_t   z;
        coord_t   u;
    } gvp_sample_t;

    ////////////////////////////////////////////////////////////////////////////
    // register word addresses
    ////////////////////////////////////////////////////////////////////////////

    localparam wb_adr_t reg_control = 4'd0;  // bit 0 run
    localparam wb_adr_t reg_status  = 4'd1;  // bit 0 finished, bit 1 busy
    localparam wb_adr_t reg_vaddr   = 4'd2;  // target slot for commit
    localparam wb_adr_t reg_n       = 4'd3;
    localparam wb_adr_t reg_iin     = 4'd4;
    localparam wb_adr_t reg_options = 4'd5;
    localparam wb_adr_t reg_nrep    = 4'd6;
    localparam wb_adr_t reg_next    = 4'd7;
    localparam wb_adr_t reg_dx      = 4'd8;
    localparam wb_adr_t reg_dy      = 4'd9;
    localparam wb_adr_t reg_dz      = 4'd10;
    localparam wb_adr_t reg_du      = 4'd11;
    localparam wb_adr_t reg_commit  = 4'd12; // write strobe only
    localparam wb_adr_t reg_section = 4'd13; // read only

endpackage

//--- hdl/gvp_regs.sv
module gvp_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  gvp_pkg::wb_adr_t   wb_adr,
    input  gvp_pkg::wb_data_t  wb_dat_w,
    output gvp_pkg::wb_data_t  wb_dat_r,
    output logic               wb_ack,
    output logic               run,
    output logic               mem_we,
    output gvp_pkg::vec_addr_t mem_waddr,
    output gvp_pkg::vector_t   mem_wvec,
    input  logic               finished,
    input  gvp_pkg::count_t    section
);
    import gvp_pkg::*;

    logic      bus_req; // new classic cycle waiting for ack
    logic      bus_wr;
    logic      busy;
    vec_addr_t vaddr;   // slot for the next commit
    vector_t   stage;   // staged vector fields
    wb_data_t  rd_mux;

    assign bus_req = wb_cyc && wb_stb && !wb_ack; // no ack while one is out
    assign bus_wr  = bus_req && wb_we;
    assign busy    = run && !finished;

    assign mem_waddr = vaddr;
    assign mem_wvec  = stage;

    ////////////////////////////////////////////////////////////////////////////
    // ack one cycle after stb
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= bus_req; // drops again because bus_req sees ack
    end

    ////////////////////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run    <= 1'b0;
            vaddr  <= '0;
            stage  <= '0;
            mem_we <= 1'b0;
        end
        else
        begin
            mem_we <= 1'b0; // single cycle strobe
            if (bus_wr)
            begin
                case (wb_adr)
                    reg_control: run           <= wb_dat_w[0];
                    reg_vaddr:   vaddr         <= wb_dat_w[num_vectors_n2-1:0];
                    reg_n:       stage.n       <= wb_dat_w;
                    reg_iin:     stage.iin     <= wb_dat_w;
                    reg_options: stage.options <= wb_dat_w;
                    reg_nrep:    stage.nrep    <= wb_dat_w;
                    reg_next:    stage.next    <= wb_dat_w[7:0]; // low byte only
                    reg_dx:      stage.dx      <= wb_dat_w;
                    reg_dy:      stage.dy      <= wb_dat_w;
                    reg_dz:      stage.dz      <= wb_dat_w;
                    reg_du:      stage.du      <= wb_dat_w;
                    reg_commit:  mem_we        <= 1'b1; // data value ignored
                    default: ;                          // status, section read only
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // readback
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        rd_mux = '0; // unmapped words read zero
        case (wb_adr)
            reg_control: rd_mux[0]   = run;
            reg_status:  rd_mux[1:0] = {busy, finished};
            reg_vaddr:   rd_mux[num_vectors_n2-1:0] = vaddr;
            reg_n:       rd_mux = stage.n;
            reg_iin:     rd_mux = stage.iin;
            reg_options: rd_mux = stage.options;
            reg_nrep:    rd_mux = stage.nrep;
            reg_next:    rd_mux = {{24{stage.next[7]}}, stage.next}; // sign extended
            reg_dx:      rd_mux = stage.dx;
            reg_dy:      rd_mux = stage.dy;
            reg_dz:      rd_mux = stage.dz;
            reg_du:      rd_mux = stage.du;
            reg_section: rd_mux = section;
            default: ;
        endcase
    end

    // data valid together with ack
    always_ff @(posedge clk)
    begin
        if (bus_req && !wb_we)
            wb_dat_r <= rd_mux;
    end

endmodule

//--- hdl/gvp_program_mem.sv
module gvp_program_mem (
    input  logic               clk,
    input  logic               we,
    input  gvp_pkg::vec_addr_t waddr,
    input  gvp_pkg::vector_t   wvec,
    input  gvp_pkg::vec_addr_t rd_addr,
    output gvp_pkg::vector_t   rd_vec
);
    import gvp_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // vector list
    ////////////////////////////////////////////////////////////////////////////

    // one whole vector per slot kept across holds
    vector_t mem [num_vectors];

    // commit from the register block
    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wvec; // full entry in one go
    end

    // executor sees the slot at pc in the same cycle
    assign rd_vec = mem[rd_addr]; // distributed ram style read

endmodule

//--- hdl/gvp_core.sv
module gvp_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    output gvp_pkg::vec_addr_t   rd_addr,
    input  gvp_pkg::vector_t     rd_vec,
    output gvp_pkg::gvp_sample_t sample,
    output logic                 finished,
    output gvp_pkg::count_t      section
);
    import gvp_pkg::*;

    gvp_state_e state;
    vec_addr_t  pc;        // program counter
    count_t     pt_cnt;    // points left in this vector
    count_t     step_cnt;  // steps left before next point
    count_t     sec;       // sections completed
    wb_data_t   opt_q;     // options of the running vector
    store_e     store_q;
    coord_t     pos_x;
    coord_t     pos_y;
    coord_t     pos_z;
    coord_t     pos_u;

    // repeat counters per slot
    count_t                 rep_cnt [num_vectors];
    logic [num_vectors-1:0] armed;   // slot counter valid, else nrep applies
    count_t                 rep_now;
    logic                   vec_end; // last data point of the vector

    assign rd_addr = pc;
    assign rep_now = armed[pc] ? rep_cnt[pc] : rd_vec.nrep;
    assign vec_end = (state == st_step) && (step_cnt == '0) && (pt_cnt == '0);

    ////////////////////////////////////////////////////////////////////////////
    // repeat counter storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (vec_end)
        begin
            if (rep_now > 0)
                rep_cnt[pc] <= rep_now - 1; // one loop pass used
            else
                rep_cnt[pc] <= rd_vec.nrep; // ready for the next visit
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // executor
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !run) // hold mode
        begin
            state    <= st_hold;
            pc       <= '0;
            sec      <= '0;
            finished <= 1'b0;
            armed    <= '0;  // every slot falls back to its nrep
            store_q  <= store_none;
            pos_x    <= '0;
            pos_y    <= '0;
            pos_z    <= '0;
            pos_u    <= '0;
        end
        else
        begin
            store_q <= store_none; // no sample unless set below
            case (state)
                st_hold:
                    state <= st_load;
                st_load:
                begin
                    if (rd_vec.n == '0) // end of program
                    begin
                        finished <= 1'b1;
                        state    <= st_done;
                    end
                    else
                    begin
                        store_q  <= store_header; // current positions
                        opt_q    <= rd_vec.options;
                        pt_cnt   <= rd_vec.n;
                        step_cnt <= rd_vec.iin;
                        state    <= st_step;
                    end
                end
                st_step:
                begin
                    pos_x <= pos_x + rd_vec.dx; // every cycle adds
                    pos_y <= pos_y + rd_vec.dy;
                    pos_z <= pos_z + rd_vec.dz;
                    pos_u <= pos_u + rd_vec.du;
                    if (step_cnt != '0)
                        step_cnt <= step_cnt - 1; // intermediate step
                    else
                    begin
                        store_q <= store_data; // point reached
                        if (pt_cnt != '0)
                        begin
                            pt_cnt   <= pt_cnt - 1;
                            step_cnt <= rd_vec.iin;
                        end
                        else
                        begin
                            sec       <= sec + 1;
                            armed[pc] <= 1'b1;
                            state     <= st_load;
                            if (rep_now > 0)
                                pc <= pc + rd_vec.next[num_vectors_n2-1:0]; // loop back
                            else
                                pc <= pc + vec_addr_t'(1);
                        end
                    end
                end
                st_done: ; // wait for run to drop
                default:
                    state <= st_hold;
            endcase
        end
    end

    // data samples already carry the step in their positions
    always_comb
    begin
        sample.store   = store_q;
        sample.section = sec;
        sample.options = opt_q;
        sample.x       = pos_x;
        sample.y       = pos_y;
        sample.z       = pos_z;
        sample.u       = pos_u;
    end

    assign section = sec;

endmodule

//--- hdl/gvp_top.sv
module gvp_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  gvp_pkg::wb_adr_t     wb_adr,
    input  gvp_pkg::wb_data_t    wb_dat_w,
    output gvp_pkg::wb_data_t    wb_dat_r,
    output logic                 wb_ack,
    output gvp_pkg::gvp_sample_t sample,
    output logic                 finished
);
    import gvp_pkg::*;

    logic      run;
    logic      mem_we;
    vec_addr_t mem_waddr;
    vector_t   mem_wvec;
    vec_addr_t rd_addr;   // executor pc
    vector_t   rd_vec;
    count_t    section;

    ////////////////////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////////////////////

    gvp_regs i_regs (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .run       (run),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wvec  (mem_wvec),
        .finished  (finished),
        .section   (section)
    );

    gvp_program_mem i_mem (
        .clk     (clk),
        .we      (mem_we),
        .waddr   (mem_waddr),
        .wvec    (mem_wvec),
        .rd_addr (rd_addr),
        .rd_vec  (rd_vec)
    );

    // executor
    gvp_core i_core (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .rd_addr  (rd_addr),
        .rd_vec   (rd_vec),
        .sample   (sample),
        .finished (finished),
        .section  (section)
    );

endmodule

//--- test/tb_gvp.sv
module tb_gvp;
    import gvp_pkg::*;

    // generous bound on all bus traffic and programs
    localparam int timeout_cycles = 4000;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_adr_t     wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_ack;
    gvp_sample_t sample;
    logic        finished;

    string       test_name;
    int          errors;          // stimulus side
    int          checks;
    int          mon_errors;      // sample monitor side
    int          mon_checks;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          seen;            // samples taken so far
    int          first_seen;      // monitor count when the model was built
    count_t      last_section;
    logic [15:0] lfsr;
    vector_t     prog [num_vectors]; // host copy of the program
    gvp_sample_t expect_q [$];       // model output

    gvp_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > timeout_cycles)
        begin
            $display("timeout: run still going after %0d cycles", timeout_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // random source and checks
    ////////////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic wb_data_t take_bits(input int nbits);
        wb_data_t r;
        int       i;
        r = '0;
        for (i = 0; i < nbits; i++)
        begin
            lfsr = lfsr_next(lfsr); // one step per bit
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check_word(input string what, input wb_data_t expected,
                              input wb_data_t actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // wishbone master called on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                              output wb_data_t rdata);
        int wait_cycles;
        wb_cyc      = 1'b1;
        wb_stb      = 1'b1;
        wb_we       = we;
        wb_adr      = adr;
        wb_dat_w    = wdata;
        wait_cycles = 0;
        do
        begin
            @(negedge clk);
            wait_cycles++;
        end
        while (!wb_ack);
        rdata  = wb_dat_r;  // valid with ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        check_word("ack latency", 32'd1, wait_cycles);
        check_word("ack after release", 32'd0, {31'd0, wb_ack}); // single pulse
    endtask

    task automatic bus_write(input wb_adr_t adr, input wb_data_t data);
        wb_data_t ignored;
        bus_access(1'b1, adr, data, ignored);
    endtask

    task automatic bus_read(input wb_adr_t adr, output wb_data_t data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic write_vector(input vec_addr_t slot, input vector_t v);
        bus_write(reg_vaddr, wb_data_t'(slot));
        bus_write(reg_n, v.n);
        bus_write(reg_iin, v.iin);
        bus_write(reg_options, v.options);
        bus_write(reg_nrep, v.nrep);
        bus_write(reg_next, {{24{v.next[7]}}, v.next});
        bus_write(reg_dx, v.dx);
        bus_write(reg_dy, v.dy);
        bus_write(reg_dz, v.dz);
        bus_write(reg_du, v.du);
        bus_write(reg_commit, '0);
        prog[slot] = v;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic gvp_sample_t make_sample(input store_e kind, input count_t sec,
        input wb_data_t opt, input coord_t x, input coord_t y, input coord_t z, input coord_t u);
        return gvp_sample_t'{kind, sec, opt, x, y, z, u};
    endfunction

    // walks prog from slot 0 with fresh repeat counters
    task automatic build_expected();
        vec_addr_t              pc;
        count_t                 sec;
        count_t                 rep_now;
        count_t                 k;
        count_t                 j;
        count_t                 rep [num_vectors];
        logic [num_vectors-1:0] armed;  // unarmed slot takes its nrep
        coord_t                 x;
        coord_t                 y;
        coord_t                 z;
        coord_t                 u;
        vector_t                v;
        int                     visits;
        expect_q.delete();
        first_seen = seen;
        pc         = '0;
        sec        = '0;
        armed      = '0;
        {x, y, z, u} = '0;
        visits     = 0;
        while (prog[pc].n != '0 && visits < 64)
        begin
            v = prog[pc];
            expect_q.push_back(make_sample(store_header, sec, v.options, x, y, z, u));
            for (k = '0; k <= v.n; k++)
            begin
                for (j = '0; j <= v.iin; j++)
                begin
                    x = x + v.dx; // every step cycle adds
                    y = y + v.dy;
                    z = z + v.dz;
                    u = u + v.du;
                end
                if (k == v.n)
                    sec = sec + 1; // counted on the last point
                expect_q.push_back(make_sample(store_data, sec, v.options, x, y, z, u));
            end
            rep_now   = armed[pc] ? rep[pc] : v.nrep;
            armed[pc] = 1'b1;
            if (rep_now != '0)
            begin
                rep[pc] = rep_now - 1;
                pc      = pc + vec_addr_t'(v.next); // loop back
            end
            else
            begin
                rep[pc] = v.nrep; // re-armed
                pc      = pc + vec_addr_t'(1);
            end
            visits++;
        end
    endtask

    // compare every real sample in order
    always @(negedge clk)
    begin
        if (!reset && sample.store != store_none)
        begin
            mon_checks++;
            assert (seen - first_seen < expect_q.size())
            else
            begin
                $display("%s: DUT sent a sample that the model does not predict", test_name);
                mon_errors++;
            end
            if (seen - first_seen < expect_q.size())
            begin
                assert (sample === expect_q[seen - first_seen])
                else
                begin
                    $display("ERR %s sample %0d: expected %h, actual %h", test_name,
                             seen - first_seen, expect_q[seen - first_seen], sample);
                    mon_errors++;
                end
            end
            seen++;
            last_section = sample.section;
        end
    end

    task automatic run_program();
        wb_data_t status;
        build_expected();
        bus_write(reg_control, 32'd1);
        do
        begin
            bus_read(reg_status, status);
            check_word("busy against finished", {31'd0, ~status[0]}, {31'd0, status[1]});
        end
        while (!status[0]);
        check_word("finished output", 32'd1, {31'd0, finished});
        check_word("samples seen", expect_q.size(), seen - first_seen);
    endtask

    task automatic small_vector(output vector_t v, input count_t nrep, input jump_t next);
        v         = '0;
        v.n       = 1 + take_bits(2); // never the end marker
        v.iin     = take_bits(2);
        v.options = take_bits(32);
        v.nrep    = nrep;
        v.next    = next;
        v.dx      = take_bits(32);
        v.dy      = take_bits(32);
        v.dz      = take_bits(32);
        v.du      = take_bits(32);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors + mon_errors;
    endtask

    task automatic end_test();
        int failed;
        failed = errors + mon_errors - errors_at_start;
        tests_run++;
        if (failed != 0)
            tests_failed++;
        $display("test %s: %s (%0d errors)", test_name, failed == 0 ? "ok" : "FAILED", failed);
    endtask

    task automatic test_registers();
        wb_data_t value;
        wb_data_t expected;
        wb_data_t rd;
        int       a;
        start_test("register_access");
        bus_read(reg_status, rd);
        check_word("status after reset", '0, rd);
        for (a = int'(reg_vaddr); a <= int'(reg_du); a++)
        begin
            value    = take_bits(32);
            expected = value;
            if (wb_adr_t'(a) == reg_vaddr)
                expected = value & wb_data_t'(num_vectors - 1); // slot bits only
            if (wb_adr_t'(a) == reg_next)
                expected = {{24{value[7]}}, value[7:0]};        // 8 bit jump
            bus_write(wb_adr_t'(a), value);
            bus_read(wb_adr_t'(a), rd);
            check_word($sformatf("readback of word %0d", a), expected, rd);
        end
        end_test();
    endtask

    task automatic test_single();
        vector_t  v;
        wb_data_t rd;
        start_test("single_vector");
        small_vector(v, '0, '0);
        v.n   = 3;            // four data points
        v.iin = take_bits(3);
        write_vector(0, v);
        write_vector(1, '0);  // end marker
        run_program();
        check_word("stream section", 32'd1, last_section);
        bus_read(reg_section, rd);
        check_word("section register", 32'd1, rd);
        end_test();
    endtask

    task automatic test_repeat();
        vector_t  v;
        wb_data_t rd;
        start_test("repeat_loop");
        bus_write(reg_control, '0);
        small_vector(v, '0, '0);
        write_vector(0, v);
        small_vector(v, 32'd2, jump_t'(-1)); // back to slot 0 twice
        write_vector(1, v);
        write_vector(2, '0);
        run_program();
        check_word("stream section", 32'd6, last_section);
        bus_read(reg_section, rd);
        check_word("section register", 32'd6, rd);
        end_test();
    endtask

    task automatic test_rerun();
        wb_data_t rd;
        int       loop_samples;
        start_test("hold_and_rerun");
        bus_write(reg_control, '0); // hold takes effect before this returns
        check_word("x in hold", '0, sample.x);
        check_word("y in hold", '0, sample.y);
        check_word("z in hold", '0, sample.z);
        check_word("u in hold", '0, sample.u);
        check_word("finished in hold", '0, {31'd0, finished});
        bus_read(reg_section, rd);
        check_word("section in hold", '0, rd);
        bus_read(reg_status, rd);
        check_word("status in hold", '0, rd);
        // stop with one repeat of slot 1 already used
        loop_samples = int'(prog[0].n + prog[1].n) + 4; // headers and data of A and B
        build_expected();
        bus_write(reg_control, 32'd1);
        while (seen - first_seen < loop_samples)
            @(negedge clk);
        bus_write(reg_control, '0);
        run_program();                // same list, same sequence
        check_word("stream section", 32'd6, last_section);
        end_test();
    endtask

    task automatic test_random();
        vector_t v;
        int      slot;
        int      jump;
        start_test("random_program");
        bus_write(reg_control, '0);
        for (slot = 0; slot < 5; slot++)
        begin
            jump = 1 + int'(take_bits(1));
            if (slot + jump > 5)
                jump = 1;             // stay inside the list
            small_vector(v, take_bits(1), jump_t'(jump));
            write_vector(vec_addr_t'(slot), v);
        end
        write_vector(vec_addr_t'(5), '0);
        run_program();
        end_test();
    endtask

    initial
    begin
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        lfsr     = 16'd73;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_registers();
        test_single();
        test_repeat();
        test_rerun();
        test_random();
        $display("tests %0d run, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
                 checks + mon_checks, errors + mon_errors);
        if (errors + mon_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- tb.f
hdl/gvp_pkg.sv
hdl/gvp_regs.sv
hdl/gvp_program_mem.sv
hdl/gvp_core.sv
hdl/gvp_top.sv
test/tb_gvp.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_gvp
	./obj_dir/Vtb_gvp | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
